//--- verilog/cpuPkg.sv
package cpuPkg;

  //////////////////////////////////////////////////////////////////////
  // Core widths and sizes
  //////////////////////////////////////////////////////////////////////
  localparam int DataWidth = 16;   // Data and instruction word
  localparam int RegCount  = 16;   // Architectural registers, R0 reads zero
  localparam int DmemDepth = 256;  // Data memory words

  //////////////////////////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////////////////////////
  typedef logic [DataWidth-1:0]         wordT;      // Data or instruction word
  typedef logic [$clog2(RegCount)-1:0]  regIdxT;    // Register index
  typedef logic [3:0]                   opcodeT;    // Opcode field, bits 15:12
  typedef logic [$clog2(DmemDepth)-1:0] dmemAddrT;  // Data memory word address

  //////////////////////////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////////////////////////
  // Register-to-register ALU ops: rd 11:8, rs 7:4, rt 3:0
  localparam opcodeT OpAdd = 4'h0;
  localparam opcodeT OpSub = 4'h1;
  localparam opcodeT OpXor = 4'h2;

  // Memory ops: reg 11:8, base 7:4, signed offset 3:0
  localparam opcodeT OpLw  = 4'h8;  // Load into rd
  localparam opcodeT OpSw  = 4'h9;  // Store data reg at base + offset

  // Stops fetch once accepted, raises hlt at write-back
  localparam opcodeT OpHlt = 4'hF;

  // Every other opcode travels down the pipe as a no-op

endpackage

//--- verilog/registerFile.sv
module registerFile (
  input  logic           clk,
  input  logic           rstN,
  input  cpuPkg::regIdxT rsIdx,    // Read port A
  input  cpuPkg::regIdxT rtIdx,    // Read port B
  input  logic           wbValid,  // Write port from write-back
  input  cpuPkg::regIdxT wbReg,
  input  cpuPkg::wordT   wbData,
  output cpuPkg::wordT   rsVal,
  output cpuPkg::wordT   rtVal
);
  import cpuPkg::*;

  wordT regs [RegCount];

  // R0 is hardwired, a same-cycle write is passed straight through
  function automatic wordT readPort(regIdxT idx);
    wordT val;
    if (idx == '0)
      val = '0;
    else if (wbValid && wbReg == idx)
      val = wbData;                    // Bypass the write in flight
    else
      val = regs[idx];
    return val;
  endfunction

  always_comb rsVal = readPort(rsIdx);
  always_comb rtVal = readPort(rtIdx);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < RegCount; i++)
        regs[i] <= '0;
    end else if (wbValid && wbReg != '0) begin  // Writes to R0 dropped
      regs[wbReg] <= wbData;
    end
  end

endmodule

//--- verilog/fetchStage.sv
module fetchStage (
  input  logic         clk,
  input  logic         rstN,
  input  logic         instrValid,  // Bench has a word for the current pc
  input  cpuPkg::wordT instrData,   // Word at address pc
  input  logic         stall,       // Load-use hazard in decode
  output logic         instrReady,
  output cpuPkg::wordT pc,          // Word index of next instruction
  output logic         ifValid,     // IF/ID holds a real instruction
  output cpuPkg::wordT ifInstr
);
  import cpuPkg::*;

  logic   halted;     // Set once HLT has been accepted
  logic   accept;     // Handshake completes this edge
  opcodeT fetchedOp;

  assign instrReady = !halted && !stall;
  assign accept     = instrValid && instrReady;
  assign fetchedOp  = instrData[15:12];

  //////////////////////////////////////////////////////////////////////
  // PC, halt latch and IF/ID valid
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc      <= '0;
      halted  <= 1'b0;
      ifValid <= 1'b0;
    end else if (!stall) begin        // Stall holds pc and IF/ID
      ifValid <= accept;               // Bubble when nothing accepted
      if (accept) begin
        pc <= pc + wordT'(1);
        if (fetchedOp == OpHlt)
          halted <= 1'b1;              // No more fetches after HLT
      end
    end
  end

  // Instruction payload, only captured on a handshake
  always_ff @(posedge clk) begin
    if (accept)
      ifInstr <= instrData;
  end

  // Once halted, fetch is frozen for good
  pcFrozenWhenHalted: assert property (@(posedge clk) disable iff (!rstN)
    halted |=> $stable(pc) && !ifValid);

endmodule

//--- verilog/decodeStage.sv
module decodeStage (
  input  logic           clk,
  input  logic           rstN,
  input  logic           ifValid,   // From IF/ID
  input  cpuPkg::wordT   ifInstr,
  input  cpuPkg::wordT   rsVal,     // Register file read data
  input  cpuPkg::wordT   rtVal,
  input  logic           exIsLoad,  // Valid LW sitting in execute
  input  cpuPkg::regIdxT exLoadRd,  // Its destination
  output cpuPkg::regIdxT rsIdx,
  output cpuPkg::regIdxT rtIdx,
  output logic           stall,     // Hold fetch, bubble into ID/EX
  output logic           exValid,   // ID/EX register
  output cpuPkg::opcodeT exOp,
  output cpuPkg::regIdxT exRd,
  output cpuPkg::regIdxT exRs,
  output cpuPkg::regIdxT exRt,
  output cpuPkg::wordT   exRsVal,
  output cpuPkg::wordT   exRtVal,
  output cpuPkg::wordT   exOffset
);
  import cpuPkg::*;

  //////////////////////////////////////////////////////////////////////
  // Field split
  //////////////////////////////////////////////////////////////////////
  opcodeT idOp;
  regIdxT idRd;      // rd for ALU and LW, data reg for SW
  logic   isAlu;
  logic   isLw;
  logic   isSw;
  logic   usesRs;    // rs read as operand or base
  logic   rsHazard;
  logic   rtHazard;
  wordT   offsetExt;

  assign idOp  = ifInstr[15:12];
  assign idRd  = ifInstr[11:8];
  assign rsIdx = ifInstr[7:4];

  assign isAlu  = idOp inside {OpAdd, OpSub, OpXor};
  assign isLw   = idOp == OpLw;
  assign isSw   = idOp == OpSw;
  assign usesRs = isAlu || isLw || isSw;

  // SW reads its data register on the second port
  assign rtIdx = isSw ? idRd : ifInstr[3:0];

  // Signed 4-bit offset widened to a full word
  assign offsetExt = {{(DataWidth-4){ifInstr[3]}}, ifInstr[3:0]};

  //////////////////////////////////////////////////////////////////////
  // Load-use hazard
  //////////////////////////////////////////////////////////////////////
  // SW data is not checked here, it is picked up from write-back in
  // the memory stage
  assign rsHazard = usesRs && rsIdx == exLoadRd;
  assign rtHazard = isAlu && rtIdx == exLoadRd;

  assign stall = ifValid && exIsLoad && exLoadRd != '0 && (rsHazard || rtHazard);

  //////////////////////////////////////////////////////////////////////
  // ID/EX register
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN)
      exValid <= 1'b0;
    else
      exValid <= ifValid && !stall;  // Bubble on a stall
  end

  // Payload follows decode every cycle, exValid qualifies it
  always_ff @(posedge clk) begin
    exOp     <= idOp;
    exRd     <= idRd;
    exRs     <= rsIdx;
    exRt     <= rtIdx;
    exRsVal  <= rsVal;
    exRtVal  <= rtVal;
    exOffset <= offsetExt;
  end

  // The stalled instruction must not also slip into execute
  stallMakesBubble: assert property (@(posedge clk) disable iff (!rstN)
    stall |=> !exValid);

endmodule

//--- verilog/executeStage.sv
module executeStage (
  input  logic           clk,
  input  logic           rstN,
  input  logic           exValid,   // ID/EX register
  input  cpuPkg::opcodeT exOp,
  input  cpuPkg::regIdxT exRd,
  input  cpuPkg::regIdxT exRs,
  input  cpuPkg::regIdxT exRt,
  input  cpuPkg::wordT   exRsVal,
  input  cpuPkg::wordT   exRtVal,
  input  cpuPkg::wordT   exOffset,
  input  logic           wbValid,   // MEM/WB result fed back
  input  cpuPkg::regIdxT wbReg,
  input  cpuPkg::wordT   wbData,
  output logic           exIsLoad,  // To decode hazard check
  output cpuPkg::regIdxT exLoadRd,
  output logic           memValid,  // EX/MEM register
  output cpuPkg::opcodeT memOp,
  output cpuPkg::regIdxT memRd,
  output cpuPkg::regIdxT memStoreReg,
  output cpuPkg::wordT   memAlu,      // ALU result or memory address
  output cpuPkg::wordT   memStoreData
);
  import cpuPkg::*;

  logic memFwdOk;  // EX/MEM holds an ALU result worth forwarding
  wordT opA;
  wordT opB;       // Also the SW store data
  wordT aluOut;

  // The instruction in ID/EX, as decode sees it
  assign exIsLoad = exValid && exOp == OpLw;
  assign exLoadRd = exRd;

  // Load data is not ready until MEM/WB
  assign memFwdOk = memValid && memRd != '0 && (memOp inside {OpAdd, OpSub, OpXor});

  //////////////////////////////////////////////////////////////////////
  // Operand forwarding
  //////////////////////////////////////////////////////////////////////
  function automatic wordT fwdOperand(regIdxT idx, wordT regVal);
    wordT pick;
    pick = regVal;
    if (wbValid && wbReg == idx)
      pick = wbData;                 // Older result
    if (memFwdOk && memRd == idx)
      pick = memAlu;                 // Newest result wins
    return pick;
  endfunction

  always_comb opA = fwdOperand(exRs, exRsVal);
  always_comb opB = fwdOperand(exRt, exRtVal);

  // ALU and address adder
  always_comb begin
    case (exOp)
      OpAdd:       aluOut = opA + opB;
      OpSub:       aluOut = opA - opB;
      OpXor:       aluOut = opA ^ opB;
      OpLw, OpSw:  aluOut = opA + exOffset;  // Base plus offset
      default:     aluOut = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // EX/MEM register
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN)
      memValid <= 1'b0;
    else
      memValid <= exValid;
  end

  always_ff @(posedge clk) begin
    memOp        <= exOp;
    memRd        <= exRd;
    memStoreReg  <= exRt;    // Data reg for SW
    memAlu       <= aluOut;
    memStoreData <= opB;
  end

endmodule

//--- verilog/memWbStage.sv
module memWbStage (
  input  logic           clk,
  input  logic           rstN,
  input  logic           memValid,      // EX/MEM register
  input  cpuPkg::opcodeT memOp,
  input  cpuPkg::regIdxT memRd,
  input  cpuPkg::regIdxT memStoreReg,
  input  cpuPkg::wordT   memAlu,
  input  cpuPkg::wordT   memStoreData,
  output logic           wbValid,       // Retire and write the register file
  output cpuPkg::regIdxT wbReg,
  output cpuPkg::wordT   wbData,
  output logic           hlt            // Sticky once HLT retires
);
  import cpuPkg::*;

  wordT     dmem [DmemDepth];
  dmemAddrT memAddr;
  logic     memWrite;
  logic     memRead;
  logic     writesReg;   // Result goes to a nonzero register
  wordT     storeData;
  logic     wbIsLoad;    // MEM/WB select between load data and ALU
  wordT     wbAlu;
  wordT     wbLoad;

  assign memAddr   = dmemAddrT'(memAlu);  // Low 8 bits of the address
  assign memWrite  = memValid && memOp == OpSw;
  assign memRead   = memValid && memOp == OpLw;
  assign writesReg = memValid && memRd != '0 && (memOp inside {OpAdd, OpSub, OpXor, OpLw});

  // Store data produced by the instruction just ahead of the SW
  assign storeData = (wbValid && wbReg == memStoreReg && memStoreReg != '0) ? wbData
                                                                            : memStoreData;

  //////////////////////////////////////////////////////////////////////
  // Data memory and MEM/WB register
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (memWrite)
      dmem[memAddr] <= storeData;
    if (memRead)
      wbLoad <= dmem[memAddr];
    wbAlu    <= memAlu;
    wbReg    <= memRd;
    wbIsLoad <= memRead;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wbValid <= 1'b0;
      hlt     <= 1'b0;
    end else begin
      wbValid <= writesReg;
      if (memValid && memOp == OpHlt)
        hlt <= 1'b1;
    end
  end

  assign wbData = wbIsLoad ? wbLoad : wbAlu;  // Write-back select

  // One memory access per cycle
  singleMemAccess: assert property (@(posedge clk) disable iff (!rstN)
    !(memWrite && memRead));

endmodule

//--- verilog/cpu.sv
module cpu (
  input  logic           clk,
  input  logic           rstN,
  input  logic           instrValid,
  input  cpuPkg::wordT   instrData,
  output logic           instrReady,
  output cpuPkg::wordT   pc,
  output logic           wbValid,  // Retirement trace
  output cpuPkg::regIdxT wbReg,
  output cpuPkg::wordT   wbData,
  output logic           hlt
);
  import cpuPkg::*;

  //////////////////////////////////////////////////////////////////////
  // Stage-to-stage wires
  //////////////////////////////////////////////////////////////////////
  logic   ifValid;
  wordT   ifInstr;
  logic   stall;
  regIdxT rsIdx, rtIdx;
  wordT   rsVal, rtVal;

  logic   exValid;                 // ID/EX
  opcodeT exOp;
  regIdxT exRd, exRs, exRt;
  wordT   exRsVal, exRtVal, exOffset;
  logic   exIsLoad;
  regIdxT exLoadRd;

  logic   memValid;                // EX/MEM
  opcodeT memOp;
  regIdxT memRd, memStoreReg;
  wordT   memAlu, memStoreData;

  fetchStage u_fetch (
    .clk, .rstN, .instrValid, .instrData, .stall,
    .instrReady, .pc, .ifValid, .ifInstr
  );

  registerFile u_regFile (
    .clk, .rstN, .rsIdx, .rtIdx, .wbValid, .wbReg, .wbData,
    .rsVal, .rtVal
  );

  decodeStage u_decode (
    .clk, .rstN, .ifValid, .ifInstr, .rsVal, .rtVal, .exIsLoad, .exLoadRd,
    .rsIdx, .rtIdx, .stall, .exValid, .exOp, .exRd, .exRs, .exRt,
    .exRsVal, .exRtVal, .exOffset
  );

  executeStage u_execute (
    .clk, .rstN, .exValid, .exOp, .exRd, .exRs, .exRt, .exRsVal, .exRtVal,
    .exOffset, .wbValid, .wbReg, .wbData, .exIsLoad, .exLoadRd,
    .memValid, .memOp, .memRd, .memStoreReg, .memAlu, .memStoreData
  );

  memWbStage u_memWb (
    .clk, .rstN, .memValid, .memOp, .memRd, .memStoreReg, .memAlu,
    .memStoreData, .wbValid, .wbReg, .wbData, .hlt
  );

endmodule

//--- bench/cpuModel.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

int unsigned lcgState = LcgSeed;  // Shared by program generator and valid drops

wordT   prog      [256];
regIdxT expReg    [256];         // Expected retirements in program order
wordT   expData   [256];
int     expTag    [256];         // Test that owns each retirement
int     expCount;
int     r0Writes;                // Writers aimed at R0
wordT   mReg      [RegCount];
wordT   mMem      [DmemDepth];
logic   storedFwd [DmemDepth];   // Last store there used a fresh data reg

function automatic int unsigned lcgNext();
  lcgState = lcgState * 32'd1664525 + 32'd1013904223;
  return lcgState >> 8;
endfunction

// Preload pattern with every address bit in the word
function automatic wordT fillWord(dmemAddrT a);
  return {~a, a ^ 8'h3C};
endfunction

function automatic regIdxT pickReg();
  return regIdxT'(lcgNext() % 6);  // Low registers R0 to R5
endfunction

function automatic regIdxT pickBase();
  return (lcgNext() % 2 == 0) ? regIdxT'(0) : pickReg();  // R0 base reuses addresses
endfunction

// One instruction on the architectural model
task automatic modelStep(wordT w, logic fwd);
  regIdxT   a;
  wordT     rsv;
  wordT     res;
  dmemAddrT addr;
  int       tag;
  a    = w[11:8];
  rsv  = mReg[w[7:4]];
  addr = dmemAddrT'(rsv + {{(DataWidth-4){w[3]}}, w[3:0]});
  res  = '0;
  tag  = 0;
  case (opcodeT'(w[15:12]))
    OpAdd: begin
      res = rsv + mReg[w[3:0]];
      tag = 1;
    end
    OpSub: begin
      res = rsv - mReg[w[3:0]];
      tag = 1;
    end
    OpXor: begin
      res = rsv ^ mReg[w[3:0]];
      tag = 1;
    end
    OpLw: begin
      res = mMem[addr];
      tag = storedFwd[addr] ? 3 : 2;
    end
    OpSw: begin
      mMem[addr]      = mReg[a];
      storedFwd[addr] = fwd;
    end
    default: ;                                            // HLT and no-ops
  endcase
  if (tag != 0 && a == '0)
    r0Writes++;
  if (tag != 0 && a != '0) begin
    mReg[a]            = res;
    expReg[expCount]   = a;
    expData[expCount]  = res;
    expTag[expCount]   = tag;
    expCount++;
  end
endtask

//////////////////////////////////////////////////////////////////////
// Random program run on the model as it is built
//////////////////////////////////////////////////////////////////////
task automatic genProgram();
  wordT   w;
  regIdxT lastWr;  // Destination of the previous writer or 0
  int     r;
  lastWr   = '0;
  expCount = 0;
  r0Writes = 0;
  for (int i = 0; i < RegCount; i++)
    mReg[i] = '0;
  for (int i = 0; i < DmemDepth; i++) begin
    mMem[i]      = fillWord(dmemAddrT'(i));
    storedFwd[i] = 1'b0;
  end
  for (int i = 0; i < 256; i++)
    prog[i] = 16'h4000;
  for (int i = 0; i < ProgLen - 1; i++) begin
    r = lcgNext() % 16;
    w[3:0] = 4'(lcgNext());
    if (lastWr != '0 && r < 4) begin        // Store the value just produced
      w[15:12] = OpSw;
      w[11:8]  = lastWr;
      w[7:4]   = pickBase();
    end else if (r < 9) begin
      w[15:12] = opcodeT'(lcgNext() % 3);
      w[11:8]  = pickReg();
      w[7:4]   = pickReg();
      w[3:0]   = pickReg();
    end else if (r < 15) begin
      w[15:12] = (r < 12) ? OpLw : OpSw;
      w[11:8]  = pickReg();
      w[7:4]   = pickBase();
    end else begin
      w[15:12] = 4'h5;                      // Unused opcode
      w[11:4]  = 8'(lcgNext());
    end
    modelStep(w, w[15:12] == OpSw && w[11:8] == lastWr && lastWr != '0);
    prog[i] = w;
    lastWr  = (w[15:12] inside {OpAdd, OpSub, OpXor, OpLw}) ? w[11:8] : '0;
  end
  prog[ProgLen-1] = {OpHlt, 12'h000};
endtask

`endif

//--- bench/cpuTb.sv
module cpuTb;
  import cpuPkg::*;

  localparam int          ClkPeriod      = 20;
  localparam int          ResetCycles    = 4;
  localparam int          ProgLen        = 200;
  localparam int unsigned LcgSeed        = 84;
  localparam int          DropOneIn      = 4;   // instrValid low about a quarter of cycles
  localparam int          WatchdogCycles = 4 * ProgLen + 50;
  localparam int          TestCount      = 6;

  logic   clk = 1'b0;
  logic   rstN;
  logic   instrValid;
  wordT   instrData;
  logic   instrReady;
  wordT   pc;
  logic   wbValid;
  regIdxT wbReg;
  wordT   wbData;
  logic   hlt;

  int   retireCnt;               // Index of the retirement now on the trace port
  wordT expPc;                   // pc implied by the handshakes so far
  wordT nextPc;
  logic drive;
  logic wbSeen;                  // Outputs sampled mid-cycle
  logic readySeen;
  int   failCnt  [1:TestCount];
  int   checkCnt [1:TestCount];  // How often the stimulus reached each test

  `include "cpuModel.svh"

  cpu u_cpu (
    .clk, .rstN, .instrValid, .instrData, .instrReady, .pc,
    .wbValid, .wbReg, .wbData, .hlt
  );

  always #(ClkPeriod/2) clk = ~clk;

  function automatic string testName(int id);
    case (id)
      1:       return "ALU forwarding";
      2:       return "load after store, load-use";
      3:       return "store data forwarding";
      4:       return "R0 writes";
      5:       return "valid drops and pc";
      default: return "halt";
    endcase
  endfunction

  task automatic logMismatch(int id, string sig, wordT expV, wordT gotV);
    failCnt[id]++;
    $display("FAIL t=%0t %s expected %h got %h (test %0d, retirement %0d)",
             $time, sig, expV, gotV, id, retireCnt);
  endtask

  task automatic logFailure(int id, string what);
    failCnt[id]++;
    $display("Error in test %0d at t=%0t: %s", id, $time, what);
  endtask

  task automatic reportRetire(int id);
    if (wbReg !== expReg[retireCnt])
      logMismatch(id, "wbReg", wordT'(expReg[retireCnt]), wordT'(wbReg));
    if (wbData !== expData[retireCnt])
      logMismatch(id, "wbData", expData[retireCnt], wbData);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus and bookkeeping
  //////////////////////////////////////////////////////////////////////
  always @(negedge clk) begin
    wbSeen    <= wbValid;
    readySeen <= instrReady;
  end

  always @(posedge clk) begin
    if (!rstN) begin
      instrValid <= 1'b0;
      expPc      <= '0;
    end else begin
      nextPc = (instrValid && readySeen) ? expPc + wordT'(1) : expPc;  // Accepted last cycle
      drive  = (lcgNext() % DropOneIn) != 0;
      if (!drive)
        checkCnt[5]++;
      instrValid <= drive;
      instrData  <= prog[nextPc[7:0]];
      expPc      <= nextPc;
    end
  end

  always @(posedge clk) begin
    if (rstN && wbSeen) begin
      if (retireCnt < expCount)
        checkCnt[expTag[retireCnt]]++;
      retireCnt <= retireCnt + 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks sampled on the falling edge
  //////////////////////////////////////////////////////////////////////
  resultMatch: assert property (@(negedge clk) disable iff (!rstN)
    wbValid && retireCnt < expCount |->
      wbReg == expReg[retireCnt] && wbData == expData[retireCnt])
    else reportRetire(expTag[retireCnt]);

  noR0Retire: assert property (@(negedge clk) disable iff (!rstN) wbValid |-> wbReg != '0)
    else logFailure(4, "wbValid raised for a write to R0");

  pcFollowsHandshake: assert property (@(negedge clk) disable iff (!rstN) pc == expPc)
    else logMismatch(5, "pc", expPc, pc);

  noExtraRetire: assert property (@(negedge clk) disable iff (!rstN)
    wbValid |-> retireCnt < expCount)
    else logFailure(5, "more results retired than the model produced");

  haltAfterLast: assert property (@(negedge clk) disable iff (!rstN)
    hlt |-> retireCnt == expCount)
    else logFailure(6, "hlt rose before every expected result had retired");

  haltQuiet: assert property (@(negedge clk) disable iff (!rstN)
    hlt |-> !instrReady && !wbValid)
    else logFailure(6, "instrReady or wbValid high while halted");

  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles without hlt", WatchdogCycles);
    $display("tests failed");
    $finish;
  end

  initial begin
    int errors;
    int badTests;
    rstN       = 1'b0;
    instrValid = 1'b0;
    instrData  = '0;
    retireCnt  = 0;
    expPc      = '0;
    wbSeen     = 1'b0;
    readySeen  = 1'b0;
    for (int i = 1; i <= TestCount; i++) begin
      failCnt[i]  = 0;
      checkCnt[i] = 0;
    end
    genProgram();
    for (int a = 0; a < DmemDepth; a++)
      u_cpu.u_memWb.dmem[a] = fillWord(dmemAddrT'(a));  // Same starting image as the model
    repeat (ResetCycles) @(posedge clk);
    rstN <= 1'b1;
    while (hlt !== 1'b1)
      @(posedge clk);
    checkCnt[6] = 1;
    repeat (10) @(posedge clk);  // Halt must stay quiet
    checkCnt[4] = r0Writes;
    if (retireCnt != expCount)
      logFailure(5, $sformatf("%0d results retired, model expects %0d", retireCnt, expCount));
    errors   = 0;
    badTests = 0;
    for (int i = 1; i <= TestCount; i++) begin
      if (checkCnt[i] == 0)
        logFailure(i, "the random program never exercised this check");
      $display("test %0d %s: reached %0d times, %0d errors",
               i, testName(i), checkCnt[i], failCnt[i]);
      errors += failCnt[i];
      if (failCnt[i] != 0)
        badTests++;
    end
    $display("summary: %0d tests, %0d with errors, %0d errors in total",
             TestCount, badTests, errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

//--- cpu.f
+incdir+bench
verilog/cpuPkg.sv
verilog/registerFile.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memWbStage.sv
verilog/cpu.sv
bench/cpuTb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = cpuTb
RTL_TOP  = cpu
FILELIST = cpu.f
OBJDIR   = obj_dir
LOG      = sim.log
PASS     = all tests passed

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
